// File: llc_geom_pkg.sv
package llc_geom_pkg;

    // slice organisation
    localparam int LLC_WAYS = 4;
    localparam int LLC_SET_BITS = 6;

    // upper set bits pick the bank, the rest address a row inside it
    localparam int LLC_BANK_BITS = 1;
    localparam int LLC_BANKS = 1 << LLC_BANK_BITS;
    localparam int LLC_ROW_BITS = LLC_SET_BITS - LLC_BANK_BITS;

    // set index as seen on the ports
    typedef logic [LLC_SET_BITS-1:0] llc_set_t;

    // way number, also used for the eviction pointer
    typedef logic [$clog2(LLC_WAYS)-1:0] llc_way_t;

    typedef logic [LLC_BANK_BITS-1:0] llc_bank_t;

    typedef logic [LLC_ROW_BITS-1:0] llc_row_t;

    // one flush request bit per way
    typedef logic [LLC_WAYS-1:0] llc_flush_t;

endpackage

// File: llc_entry_pkg.sv
package llc_entry_pkg;

    // data line held per set and way
    localparam int LLC_LINE_BITS = 128;
    typedef logic [LLC_LINE_BITS-1:0] line_t;

    // address tag
    localparam int LLC_TAG_BITS = 20;
    typedef logic [LLC_TAG_BITS-1:0] llc_tag_t;

    // coherence state, stored exactly as the controller writes it
    localparam int LLC_STATE_BITS = 3;
    typedef logic [LLC_STATE_BITS-1:0] llc_state_t;

endpackage

// File: llc_wr_if.sv
`timescale 1ns/10ps

interface llc_wr_if;
    import llc_geom_pkg::*;
    import llc_entry_pkg::*;

    // row inside the selected bank
    llc_row_t row;

    // enables per way and bank
    logic line_we [LLC_WAYS][LLC_BANKS];
    logic tag_we [LLC_WAYS][LLC_BANKS];
    logic meta_we [LLC_WAYS][LLC_BANKS];

    // eviction pointer is kept per set, so only the bank matters
    logic evict_we [LLC_BANKS];

    line_t line;
    llc_tag_t tag;
    llc_state_t state;
    logic dirty;
    llc_way_t evict_way;

    modport decode (
        output row, line_we, tag_we, meta_we, evict_we,
        output line, tag, state, dirty, evict_way
    );

    modport array (
        input row, line_we, tag_we, meta_we, evict_we,
        input line, tag, state, dirty, evict_way
    );

endinterface

// File: llc_bank_rd_if.sv
`timescale 1ns/10ps

interface llc_bank_rd_if;
    import llc_geom_pkg::*;
    import llc_entry_pkg::*;

    // registered contents of the addressed row in every bank
    line_t line [LLC_WAYS][LLC_BANKS];
    llc_tag_t tag [LLC_WAYS][LLC_BANKS];
    llc_state_t state [LLC_WAYS][LLC_BANKS];
    logic dirty [LLC_WAYS][LLC_BANKS];
    llc_way_t evict_way [LLC_BANKS];

    modport array (
        output line, tag, state, dirty, evict_way
    );

    modport select (
        input line, tag, state, dirty, evict_way
    );

endinterface

// File: llc_wr_decode.sv
`timescale 1ns/10ps

module llc_wr_decode (
    input  llc_geom_pkg::llc_set_t     set_in,
    input  llc_geom_pkg::llc_way_t     way,
    input  logic                       wr_en,
    input  llc_geom_pkg::llc_flush_t   wr_rst_flush,
    input  logic                       wr_en_evict_way,
    input  llc_entry_pkg::line_t       wr_data_line,
    input  llc_entry_pkg::llc_tag_t    wr_data_tag,
    input  llc_entry_pkg::llc_state_t  wr_data_state,
    input  logic                       wr_data_dirty_bit,
    input  llc_geom_pkg::llc_way_t     wr_data_evict_way,
    llc_wr_if.decode                   wr
);
    import llc_geom_pkg::*;
    import llc_entry_pkg::*;

    llc_bank_t bank;
    logic      bank_sel [LLC_BANKS];
    logic      way_sel [LLC_WAYS];

    assign bank = set_in[LLC_SET_BITS-1 -: LLC_BANK_BITS];

    always_comb begin
        for (int b = 0; b < LLC_BANKS; b++) begin
            bank_sel[b] = (bank == llc_bank_t'(b));
        end
    end

    // a flush bit hits its way regardless of the way input
    always_comb begin
        for (int w = 0; w < LLC_WAYS; w++) begin
            way_sel[w] = wr_rst_flush[w] || (wr_en && (way == llc_way_t'(w)));
        end
    end

    always_comb begin
        for (int w = 0; w < LLC_WAYS; w++) begin
            for (int b = 0; b < LLC_BANKS; b++) begin
                wr.meta_we[w][b] = way_sel[w] && bank_sel[b];
                // flush alone never touches line or tag
                wr.line_we[w][b] = way_sel[w] && bank_sel[b] && wr_en;
                wr.tag_we[w][b] = way_sel[w] && bank_sel[b] && wr_en;
            end
        end
    end

    always_comb begin
        for (int b = 0; b < LLC_BANKS; b++) begin
            wr.evict_we[b] = wr_en_evict_way && bank_sel[b];
        end
    end

    assign wr.row = set_in[LLC_ROW_BITS-1:0];

    assign wr.line = wr_data_line;
    assign wr.tag = wr_data_tag;
    assign wr.state = wr_data_state;
    assign wr.dirty = wr_data_dirty_bit;
    assign wr.evict_way = wr_data_evict_way;

endmodule

// File: llc_way_banks.sv
`timescale 1ns/10ps

module llc_way_banks (
    input  logic        clk,
    input  logic        rst,
    input  logic        rd_en,
    llc_wr_if.array     wr,
    llc_bank_rd_if.array rd
);
    import llc_geom_pkg::*;
    import llc_entry_pkg::*;

    for (genvar w = 0; w < LLC_WAYS; w++) begin : g_way
        for (genvar b = 0; b < LLC_BANKS; b++) begin : g_bank
            line_t      line_mem [2**LLC_ROW_BITS];
            llc_tag_t   tag_mem [2**LLC_ROW_BITS];
            llc_state_t state_mem [2**LLC_ROW_BITS];
            logic       dirty_mem [2**LLC_ROW_BITS];

            always_ff @(posedge clk) begin
                if (wr.line_we[w][b]) begin
                    line_mem[wr.row] <= wr.line;
                end
            end

            always_ff @(posedge clk) begin
                if (wr.tag_we[w][b]) begin
                    tag_mem[wr.row] <= wr.tag;
                end
            end

            // state and dirty share the flush-aware enable
            always_ff @(posedge clk) begin
                if (wr.meta_we[w][b]) begin
                    state_mem[wr.row] <= wr.state;
                    dirty_mem[wr.row] <= wr.dirty;
                end
            end

            // read-first: a write in the same cycle lands after this sample
            always_ff @(posedge clk) begin
                if (rst) begin
                    rd.line[w][b] <= '0;
                    rd.tag[w][b] <= '0;
                    rd.state[w][b] <= '0;
                    rd.dirty[w][b] <= 1'b0;
                end else if (rd_en) begin
                    rd.line[w][b] <= line_mem[wr.row];
                    rd.tag[w][b] <= tag_mem[wr.row];
                    rd.state[w][b] <= state_mem[wr.row];
                    rd.dirty[w][b] <= dirty_mem[wr.row];
                end
            end
        end
    end

    // one eviction pointer per set, banked like the ways
    for (genvar b = 0; b < LLC_BANKS; b++) begin : g_evict
        llc_way_t evict_mem [2**LLC_ROW_BITS];

        always_ff @(posedge clk) begin
            if (wr.evict_we[b]) begin
                evict_mem[wr.row] <= wr.evict_way;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                rd.evict_way[b] <= '0;
            end else if (rd_en) begin
                rd.evict_way[b] <= evict_mem[wr.row];
            end
        end
    end

endmodule

// File: llc_rd_select.sv
`timescale 1ns/10ps

module llc_rd_select (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd_en,
    input  llc_geom_pkg::llc_set_t     set_in,
    llc_bank_rd_if.select              rd,
    output llc_entry_pkg::line_t       rd_data_line [llc_geom_pkg::LLC_WAYS],
    output llc_entry_pkg::llc_tag_t    rd_data_tag [llc_geom_pkg::LLC_WAYS],
    output llc_entry_pkg::llc_state_t  rd_data_state [llc_geom_pkg::LLC_WAYS],
    output logic                       rd_data_dirty_bit [llc_geom_pkg::LLC_WAYS],
    output llc_geom_pkg::llc_way_t     rd_data_evict_way
);
    import llc_geom_pkg::*;
    import llc_entry_pkg::*;

    // bank of the read in flight, taken on the same edge as the bank data
    llc_bank_t rd_bank;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_bank <= '0;
        end else if (rd_en) begin
            rd_bank <= set_in[LLC_SET_BITS-1 -: LLC_BANK_BITS];
        end
    end

    always_comb begin
        for (int w = 0; w < LLC_WAYS; w++) begin
            rd_data_line[w] = rd.line[w][rd_bank];
            rd_data_tag[w] = rd.tag[w][rd_bank];
            rd_data_state[w] = rd.state[w][rd_bank];
            rd_data_dirty_bit[w] = rd.dirty[w][rd_bank];
        end
    end

    assign rd_data_evict_way = rd.evict_way[rd_bank];

endmodule

// File: llc_localmem.sv
`timescale 1ns/10ps

module llc_localmem (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd_en,
    input  llc_geom_pkg::llc_set_t     set_in,
    input  llc_geom_pkg::llc_way_t     way,

    // write data
    input  llc_entry_pkg::line_t       wr_data_line,
    input  llc_entry_pkg::llc_tag_t    wr_data_tag,
    input  llc_entry_pkg::llc_state_t  wr_data_state,
    input  logic                       wr_data_dirty_bit,
    input  llc_geom_pkg::llc_way_t     wr_data_evict_way,

    // strobes
    input  logic                       wr_en,
    input  llc_geom_pkg::llc_flush_t   wr_rst_flush,
    input  logic                       wr_en_evict_way,

    // all ways of the set read last
    output llc_entry_pkg::line_t       rd_data_line [llc_geom_pkg::LLC_WAYS],
    output llc_entry_pkg::llc_tag_t    rd_data_tag [llc_geom_pkg::LLC_WAYS],
    output llc_entry_pkg::llc_state_t  rd_data_state [llc_geom_pkg::LLC_WAYS],
    output logic                       rd_data_dirty_bit [llc_geom_pkg::LLC_WAYS],
    output llc_geom_pkg::llc_way_t     rd_data_evict_way
);

    llc_wr_if      wr_bus ();
    llc_bank_rd_if rd_bus ();

    llc_wr_decode u_wr_decode (
        .set_in            (set_in),
        .way               (way),
        .wr_en             (wr_en),
        .wr_rst_flush      (wr_rst_flush),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_state     (wr_data_state),
        .wr_data_dirty_bit (wr_data_dirty_bit),
        .wr_data_evict_way (wr_data_evict_way),
        .wr                (wr_bus.decode)
    );

    // storage, one cycle from rd_en to bank data
    llc_way_banks u_way_banks (
        .clk   (clk),
        .rst   (rst),
        .rd_en (rd_en),
        .wr    (wr_bus.array),
        .rd    (rd_bus.array)
    );

    llc_rd_select u_rd_select (
        .clk               (clk),
        .rst               (rst),
        .rd_en             (rd_en),
        .set_in            (set_in),
        .rd                (rd_bus.select),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_state     (rd_data_state),
        .rd_data_dirty_bit (rd_data_dirty_bit),
        .rd_data_evict_way (rd_data_evict_way)
    );

endmodule

// File: llc_localmem_checker.sv
`timescale 1ns/10ps

module llc_localmem_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_en,
    input  llc_geom_pkg::llc_set_t    set_in,
    input  llc_geom_pkg::llc_way_t    way,
    input  logic                      wr_en,
    input  llc_geom_pkg::llc_flush_t  wr_rst_flush,
    input  logic                      wr_en_evict_way,
    input  llc_entry_pkg::line_t      rd_data_line [llc_geom_pkg::LLC_WAYS]
);
    import llc_geom_pkg::*;

    // failed assertions so far
    int fail_count = 0;

    // read data only moves on an edge that took a read
    for (genvar w = 0; w < LLC_WAYS; w++) begin : g_hold
        assert property (@(posedge clk) disable iff (rst)
            !rd_en |=> $stable(rd_data_line[w]))
        else begin
            fail_count++;
            $error("rd_data_line way %0d changed without a read", w);
        end
    end

    // every strobe needs a defined set index
    assert property (@(posedge clk) disable iff (rst)
        (rd_en || wr_en || wr_en_evict_way || (|wr_rst_flush)) |-> !$isunknown(set_in))
    else begin
        fail_count++;
        $error("set_in has unknown bits while a strobe is high");
    end

    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(way))
    else begin
        fail_count++;
        $error("way has unknown bits while wr_en is high");
    end

endmodule

// File: tb_llc_localmem.sv
`timescale 1ns/10ps

module tb_llc_localmem;
    import llc_geom_pkg::*;
    import llc_entry_pkg::*;

    localparam int OP_IDLE = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_FLUSH = 2;
    localparam int OP_EVICT = 3;
    localparam int MAX_OPS = 48;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_SETS = 2**LLC_SET_BITS;

    logic        clk;
    logic        rst;
    logic        rd_en;
    llc_set_t    set_in;
    llc_way_t    way;
    line_t       wr_data_line;
    llc_tag_t    wr_data_tag;
    llc_state_t  wr_data_state;
    logic        wr_data_dirty_bit;
    llc_way_t    wr_data_evict_way;
    logic        wr_en;
    llc_flush_t  wr_rst_flush;
    logic        wr_en_evict_way;
    line_t       rd_data_line [LLC_WAYS];
    llc_tag_t    rd_data_tag [LLC_WAYS];
    llc_state_t  rd_data_state [LLC_WAYS];
    logic        rd_data_dirty_bit [LLC_WAYS];
    llc_way_t    rd_data_evict_way;

    llc_localmem DUT (
        .clk               (clk),
        .rst               (rst),
        .rd_en             (rd_en),
        .set_in            (set_in),
        .way               (way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_state     (wr_data_state),
        .wr_data_dirty_bit (wr_data_dirty_bit),
        .wr_data_evict_way (wr_data_evict_way),
        .wr_en             (wr_en),
        .wr_rst_flush      (wr_rst_flush),
        .wr_en_evict_way   (wr_en_evict_way),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_state     (rd_data_state),
        .rd_data_dirty_bit (rd_data_dirty_bit),
        .rd_data_evict_way (rd_data_evict_way)
    );

    bind llc_localmem llc_localmem_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .rd_en           (rd_en),
        .set_in          (set_in),
        .way             (way),
        .wr_en           (wr_en),
        .wr_rst_flush    (wr_rst_flush),
        .wr_en_evict_way (wr_en_evict_way),
        .rd_data_line    (rd_data_line)
    );

    // operation table
    int          op_kind [MAX_OPS];
    bit          op_read [MAX_OPS];
    llc_set_t    op_set [MAX_OPS];
    llc_way_t    op_way [MAX_OPS];
    llc_flush_t  op_mask [MAX_OPS];
    llc_state_t  op_state [MAX_OPS];
    logic        op_dirty [MAX_OPS];
    llc_way_t    op_evict [MAX_OPS];
    string       op_name [MAX_OPS];
    int          n_ops;

    // shadow copy of the storage, with a flag for entries ever written
    line_t       sh_line [NUM_SETS][LLC_WAYS];
    llc_tag_t    sh_tag [NUM_SETS][LLC_WAYS];
    llc_state_t  sh_state [NUM_SETS][LLC_WAYS];
    logic        sh_dirty [NUM_SETS][LLC_WAYS];
    llc_way_t    sh_evict [NUM_SETS];
    bit          data_known [NUM_SETS][LLC_WAYS];
    bit          meta_known [NUM_SETS][LLC_WAYS];
    bit          evict_known [NUM_SETS];

    // expected outputs of the read in flight and of the last read
    line_t       nx_line [LLC_WAYS];
    llc_tag_t    nx_tag [LLC_WAYS];
    llc_state_t  nx_state [LLC_WAYS];
    logic        nx_dirty [LLC_WAYS];
    bit          nx_data_ok [LLC_WAYS];
    bit          nx_meta_ok [LLC_WAYS];
    llc_way_t    nx_evict;
    bit          nx_evict_ok;
    line_t       exp_line [LLC_WAYS];
    llc_tag_t    exp_tag [LLC_WAYS];
    llc_state_t  exp_state [LLC_WAYS];
    logic        exp_dirty [LLC_WAYS];
    bit          exp_data_ok [LLC_WAYS];
    bit          exp_meta_ok [LLC_WAYS];
    llc_way_t    exp_evict;
    bit          exp_evict_ok;

    bit          read_pending;
    bit          have_read;
    int          error_count;
    int          cycle_count;
    int          timeout_limit;
    string       last_name;

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            $display("timeout: run did not end within %0d cycles", timeout_limit);
            $display("errors: %0d", error_count);
            $display("Test failed");
            $finish;
        end
    end

    task automatic add_op(input int kind, input bit rd, input int set, input int w,
                          input llc_flush_t mask, input int state, input logic dirty,
                          input int evict, input string name);
        op_kind[n_ops] = kind;
        op_read[n_ops] = rd;
        op_set[n_ops] = llc_set_t'(set);
        op_way[n_ops] = llc_way_t'(w);
        op_mask[n_ops] = mask;
        op_state[n_ops] = llc_state_t'(state);
        op_dirty[n_ops] = dirty;
        op_evict[n_ops] = llc_way_t'(evict);
        op_name[n_ops] = name;
        n_ops = n_ops + 1;
    endtask

    // expected values come from the shadow before this cycle's write
    task automatic take_read(input int s);
        for (int w = 0; w < LLC_WAYS; w++) begin
            nx_line[w] = sh_line[s][w];
            nx_tag[w] = sh_tag[s][w];
            nx_state[w] = sh_state[s][w];
            nx_dirty[w] = sh_dirty[s][w];
            nx_data_ok[w] = data_known[s][w];
            nx_meta_ok[w] = meta_known[s][w];
        end
        nx_evict = sh_evict[s];
        nx_evict_ok = evict_known[s];
        read_pending = 1'b1;
    endtask

    task automatic apply_op(input int i);
        line_t    line_val;
        llc_tag_t tag_val;
        int       s;
        line_val = {$urandom, $urandom, $urandom, $urandom};
        tag_val = llc_tag_t'($urandom);
        s = op_set[i];
        if (op_read[i]) begin
            take_read(s);
        end
        rd_en = op_read[i];
        set_in = op_set[i];
        way = op_way[i];
        wr_en = (op_kind[i] == OP_WRITE);
        wr_rst_flush = (op_kind[i] == OP_FLUSH) ? op_mask[i] : '0;
        wr_en_evict_way = (op_kind[i] == OP_EVICT);
        wr_data_line = line_val;
        wr_data_tag = tag_val;
        wr_data_state = op_state[i];
        wr_data_dirty_bit = op_dirty[i];
        wr_data_evict_way = op_evict[i];
        if (op_kind[i] == OP_WRITE) begin
            sh_line[s][op_way[i]] = line_val;
            sh_tag[s][op_way[i]] = tag_val;
            sh_state[s][op_way[i]] = op_state[i];
            sh_dirty[s][op_way[i]] = op_dirty[i];
            data_known[s][op_way[i]] = 1'b1;
            meta_known[s][op_way[i]] = 1'b1;
        end else if (op_kind[i] == OP_FLUSH) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                if (op_mask[i][w]) begin
                    sh_state[s][w] = op_state[i];
                    sh_dirty[s][w] = op_dirty[i];
                    meta_known[s][w] = 1'b1;
                end
            end
        end else if (op_kind[i] == OP_EVICT) begin
            sh_evict[s] = op_evict[i];
            evict_known[s] = 1'b1;
        end
    endtask

    task automatic drive_idle();
        rd_en = 1'b0;
        wr_en = 1'b0;
        wr_rst_flush = '0;
        wr_en_evict_way = 1'b0;
    endtask

    task automatic compare_outputs(input string name);
        if (read_pending) begin
            exp_line = nx_line;
            exp_tag = nx_tag;
            exp_state = nx_state;
            exp_dirty = nx_dirty;
            exp_data_ok = nx_data_ok;
            exp_meta_ok = nx_meta_ok;
            exp_evict = nx_evict;
            exp_evict_ok = nx_evict_ok;
            have_read = 1'b1;
            read_pending = 1'b0;
        end
        if (have_read) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                if (exp_data_ok[w] && rd_data_line[w] !== exp_line[w]) begin
                    $display("** Error: %s line way %0d expected %h actual %h",
                             name, w, exp_line[w], rd_data_line[w]);
                    error_count++;
                end
                if (exp_data_ok[w] && rd_data_tag[w] !== exp_tag[w]) begin
                    $display("** Error: %s tag way %0d expected %h actual %h",
                             name, w, exp_tag[w], rd_data_tag[w]);
                    error_count++;
                end
                if (exp_meta_ok[w] && rd_data_state[w] !== exp_state[w]) begin
                    $display("** Error: %s state way %0d expected %h actual %h",
                             name, w, exp_state[w], rd_data_state[w]);
                    error_count++;
                end
                if (exp_meta_ok[w] && rd_data_dirty_bit[w] !== exp_dirty[w]) begin
                    $display("** Error: %s dirty way %0d expected %b actual %b",
                             name, w, exp_dirty[w], rd_data_dirty_bit[w]);
                    error_count++;
                end
            end
            if (exp_evict_ok && rd_data_evict_way !== exp_evict) begin
                $display("** Error: %s evict_way expected %0d actual %0d",
                         name, exp_evict, rd_data_evict_way);
                error_count++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        set_in = '0;
        way = '0;
        wr_data_line = '0;
        wr_data_tag = '0;
        wr_data_state = '0;
        wr_data_dirty_bit = 1'b0;
        wr_data_evict_way = '0;
        drive_idle();
        void'($urandom(32'h091c3627));
        n_ops = 0;
        error_count = 0;
        cycle_count = 0;
        timeout_limit = 0;
        read_pending = 1'b0;
        have_read = 1'b0;
        last_name = "reset";

        // sets 3 and 35 share row 3 in different banks
        for (int w = 0; w < LLC_WAYS; w++) begin
            add_op(OP_WRITE, 0, 3, w, '0, w + 1, w % 2, 0, "fill_bank0");
        end
        for (int w = 0; w < LLC_WAYS; w++) begin
            add_op(OP_WRITE, 0, 35, w, '0, 7 - w, (w + 1) % 2, 0, "fill_bank1");
        end
        add_op(OP_IDLE, 1, 3, 0, '0, 0, 0, 0, "read_bank0");
        add_op(OP_IDLE, 1, 35, 0, '0, 0, 0, 0, "read_bank1");
        add_op(OP_WRITE, 0, 3, 2, '0, 6, 1, 0, "write_one_way");
        add_op(OP_WRITE, 0, 35, 0, '0, 2, 1, 0, "write_other_bank");
        add_op(OP_IDLE, 1, 3, 0, '0, 0, 0, 0, "ways_isolated");
        add_op(OP_IDLE, 1, 35, 0, '0, 0, 0, 0, "banks_isolated");
        add_op(OP_FLUSH, 0, 3, 0, 4'b0101, 5, 0, 0, "flush_mask_bank0");
        add_op(OP_FLUSH, 0, 35, 3, 4'b1110, 1, 1, 0, "flush_mask_bank1");
        add_op(OP_IDLE, 1, 3, 0, '0, 0, 0, 0, "flush_readback_bank0");
        add_op(OP_IDLE, 1, 35, 0, '0, 0, 0, 0, "flush_readback_bank1");
        add_op(OP_EVICT, 0, 3, 0, '0, 0, 0, 2, "evict_set3");
        add_op(OP_EVICT, 0, 35, 0, '0, 0, 0, 1, "evict_set35");
        add_op(OP_EVICT, 0, 10, 0, '0, 0, 0, 3, "evict_set10");
        add_op(OP_WRITE, 0, 10, 3, '0, 4, 1, 0, "write_set10");
        add_op(OP_IDLE, 1, 3, 0, '0, 0, 0, 0, "evict_readback_set3");
        add_op(OP_IDLE, 1, 35, 0, '0, 0, 0, 0, "evict_readback_set35");
        add_op(OP_IDLE, 1, 10, 0, '0, 0, 0, 0, "evict_readback_set10");
        // set moves to other contents, so a capture without rd_en would show
        for (int k = 0; k < 3; k++) begin
            add_op(OP_IDLE, 0, 35, 0, '0, 0, 0, 0, "hold_no_read");
        end
        add_op(OP_IDLE, 1, 3, 0, '0, 0, 0, 0, "read_before_write");
        add_op(OP_WRITE, 1, 3, 1, '0, 4, 0, 0, "read_during_write");
        add_op(OP_IDLE, 0, 3, 0, '0, 0, 0, 0, "hold_old_contents");
        add_op(OP_IDLE, 1, 3, 0, '0, 0, 0, 0, "read_after_write");

        timeout_limit = 2 * n_ops + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < n_ops; i++) begin
            @(posedge clk);
            #1;
            compare_outputs(last_name);
            #1;
            apply_op(i);
            last_name = op_name[i];
        end
        @(posedge clk);
        #1;
        compare_outputs(last_name);
        #1;
        drive_idle();
        @(posedge clk);
        #1;
        compare_outputs("final_hold");

        if (DUT.u_checker.fail_count != 0) begin
            $display("assertions failed %0d times", DUT.u_checker.fail_count);
        end
        error_count = error_count + DUT.u_checker.fail_count;
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
llc_geom_pkg.sv
llc_entry_pkg.sv
llc_wr_if.sv
llc_bank_rd_if.sv
llc_wr_decode.sv
llc_way_banks.sv
llc_rd_select.sv
llc_localmem.sv
llc_localmem_checker.sv
tb_llc_localmem.sv
